// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = cpu_core_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/core_pkg.sv ====
package core_pkg;

  // Program counter layout: bank, page, step
  typedef struct packed {
    logic       bank;
    logic [3:0] page;
    logic [7:0] step;
  } pc_t;

  typedef struct packed {
    logic [3:0] op4;                // JP, CALL, RETD, LD X,e
    logic [7:0] imm8;
  } instr_wide_t;

  typedef struct packed {
    logic [7:0] op8;                // LD A,i and LDPX group
    logic [3:0] imm4;
  } instr_narrow_t;

  // One 12-bit ROM word, read with either opcode width
  typedef union packed {
    instr_wide_t   wide;
    instr_narrow_t narrow;
  } instr_u;

  typedef enum logic [3:0] {
    OP_NOP,
    OP_JP,
    OP_CALL,
    OP_RETD,
    OP_RET,
    OP_RETS,
    OP_LD_A_I,
    OP_LD_X_E,
    OP_LDPX_MX_I
  } op_e;

  typedef struct packed {
    op_e        op;
    logic [7:0] imm8;               // 4-bit immediates sit in [3:0]
  } decoded_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [3:0]  pwdata;
  } apb_req_t;

  typedef struct packed {
    logic       pready;
    logic [3:0] prdata;
  } apb_rsp_t;

  // Register updates, one enable per field
  typedef struct packed {
    logic        pc_we;
    pc_t         pc;
    logic        a_we;
    logic [3:0]  a;
    logic        x_we;
    logic [11:0] x;
    logic        sp_we;
    logic [7:0]  sp;
    logic        done;              // Last cycle of the instruction
  } wb_t;

  typedef struct packed {
    pc_t         pc;
    logic [3:0]  a;
    logic [11:0] x;
    logic [7:0]  sp;
  } arch_state_t;

endpackage

// ==== rtl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
  parameter core_pkg::pc_t RESET_PC = 13'h0100,
  parameter logic [7:0]    RESET_SP = 8'h48
) (
  input  logic                  clk,
  input  logic                  rst,
  output core_pkg::pc_t         rom_addr,
  input  core_pkg::instr_u      rom_data,
  output core_pkg::apb_req_t    apb_req,
  input  core_pkg::apb_rsp_t    apb_rsp,
  output logic                  retire,
  output core_pkg::arch_state_t state
);

  core_pkg::decoded_t dec;
  core_pkg::wb_t      wb;

  assign rom_addr = state.pc;  // Fetch straight from the live PC

  instr_decode decode_i (
    .word (rom_data),
    .dec  (dec)
  );

  micro_sequencer seq_i (
    .clk     (clk),
    .rst     (rst),
    .dec     (dec),
    .state   (state),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .wb      (wb)
  );

  reg_writeback #(
    .RESET_PC (RESET_PC),
    .RESET_SP (RESET_SP)
  ) wb_i (
    .clk    (clk),
    .rst    (rst),
    .wb     (wb),
    .state  (state),
    .retire (retire)
  );

endmodule

// ==== rtl/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
  input  core_pkg::instr_u   word,
  output core_pkg::decoded_t dec
);

  logic [11:0] raw;
  logic [3:0]  op4;
  logic [7:0]  op8;

  assign raw = word;
  assign op4 = word.wide.op4;
  assign op8 = word.narrow.op8;

  always_comb begin
    dec.op   = core_pkg::OP_NOP;
    dec.imm8 = 8'h00;

    // Full-word encodings first, they carry no operand
    if (raw == 12'hFDF) begin
      dec.op = core_pkg::OP_RET;
    end else if (raw == 12'hFDE) begin
      dec.op = core_pkg::OP_RETS;
    end else begin
      // Narrow view, 8-bit opcode with a nibble operand
      case (op8)
        8'hE0: begin
          dec.op   = core_pkg::OP_LD_A_I;
          dec.imm8 = {4'h0, word.narrow.imm4};
        end
        8'hE6: begin
          dec.op   = core_pkg::OP_LDPX_MX_I;
          dec.imm8 = {4'h0, word.narrow.imm4};
        end
        default: begin
          // Wide view, 4-bit opcode with a byte operand
          case (op4)
            4'h0: begin
              dec.op   = core_pkg::OP_JP;
              dec.imm8 = word.wide.imm8;
            end
            4'h1: begin
              dec.op   = core_pkg::OP_RETD;
              dec.imm8 = word.wide.imm8;
            end
            4'h4: begin
              dec.op   = core_pkg::OP_CALL;
              dec.imm8 = word.wide.imm8;
            end
            4'hB: begin
              dec.op   = core_pkg::OP_LD_X_E;
              dec.imm8 = word.wide.imm8;
            end
            default: begin
              dec.op   = core_pkg::OP_NOP;  // Unlisted words
              dec.imm8 = 8'h00;
            end
          endcase
        end
      endcase
    end
  end

endmodule

// ==== rtl/micro_sequencer.sv ====
`timescale 1ns/1ps

module micro_sequencer (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::decoded_t    dec,
  input  core_pkg::arch_state_t state,
  output core_pkg::apb_req_t    apb_req,
  input  core_pkg::apb_rsp_t    apb_rsp,
  output core_pkg::wb_t         wb
);

  typedef enum logic [2:0] {
    S_FETCH,
    S_SETUP,
    S_ACCESS,
    S_DONE,
    S_RETIRE
  } seq_state_e;

  seq_state_e     seq_q;
  core_pkg::op_e  op_q;
  logic [7:0]     imm_q;
  logic [2:0]     idx_q;             // Transfer index within the op
  logic [11:0]    ret_buf_q;         // {PCP, PCSH, PCSL} as popped
  logic [2:0]     last_idx;
  logic           uses_bus;
  logic [7:0]     call_step;
  logic [7:0]     ret_step;

  assign uses_bus = dec.op inside {core_pkg::OP_CALL, core_pkg::OP_RET, core_pkg::OP_RETS,
                                   core_pkg::OP_RETD, core_pkg::OP_LDPX_MX_I};

  always_comb begin
    case (op_q)
      core_pkg::OP_CALL,
      core_pkg::OP_RET,
      core_pkg::OP_RETS: last_idx = 3'd2;
      core_pkg::OP_RETD: last_idx = 3'd4;  // Three pops, two MX writes
      default:           last_idx = 3'd0;
    endcase
  end

  assign call_step = state.pc.step + 8'd1;  // Wraps within the page
  assign ret_step  = ret_buf_q[7:0] + {7'd0, op_q == core_pkg::OP_RETS};

  always_ff @(posedge clk) begin
    if (rst) begin
      seq_q <= S_FETCH;
      idx_q <= 3'd0;
    end else begin
      case (seq_q)
        S_FETCH: begin
          idx_q <= 3'd0;
          seq_q <= uses_bus ? S_SETUP : S_DONE;
        end
        S_SETUP: seq_q <= S_ACCESS;
        S_ACCESS: begin
          if (apb_rsp.pready) begin
            if (idx_q == last_idx) begin
              seq_q <= S_DONE;
            end else begin
              idx_q <= idx_q + 3'd1;
              seq_q <= S_SETUP;
            end
          end
        end
        S_DONE:  seq_q <= S_RETIRE;
        default: seq_q <= S_FETCH;  // Retire cycle, PC already updated
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (seq_q == S_FETCH) begin
      op_q  <= dec.op;
      imm_q <= dec.imm8;
    end
    if (seq_q == S_ACCESS && apb_rsp.pready && !apb_req.pwrite) begin
      case (idx_q)
        3'd0:    ret_buf_q[3:0]  <= apb_rsp.prdata;  // PCSL
        3'd1:    ret_buf_q[7:4]  <= apb_rsp.prdata;  // PCSH
        3'd2:    ret_buf_q[11:8] <= apb_rsp.prdata;  // PCP
        default: ret_buf_q       <= ret_buf_q;
      endcase
    end
  end

  // Request comes from registers only, so it stays put during waits
  always_comb begin
    apb_req = '0;
    if (seq_q == S_SETUP || seq_q == S_ACCESS) begin
      apb_req.psel    = 1'b1;
      apb_req.penable = (seq_q == S_ACCESS);
      case (op_q)
        core_pkg::OP_CALL: begin
          apb_req.pwrite = 1'b1;
          apb_req.paddr  = {4'h0, state.sp - {5'd0, idx_q} - 8'd1};
          case (idx_q)
            3'd0:    apb_req.pwdata = state.pc.page;
            3'd1:    apb_req.pwdata = call_step[7:4];
            default: apb_req.pwdata = call_step[3:0];
          endcase
        end
        core_pkg::OP_RET,
        core_pkg::OP_RETS,
        core_pkg::OP_RETD: begin
          if (idx_q < 3'd3) begin
            apb_req.paddr = {4'h0, state.sp + {5'd0, idx_q}};  // Pop at SP upward
          end else if (idx_q == 3'd3) begin
            apb_req.pwrite = 1'b1;
            apb_req.paddr  = state.x;
            apb_req.pwdata = imm_q[3:0];
          end else begin
            apb_req.pwrite = 1'b1;
            apb_req.paddr  = state.x + 12'd1;
            apb_req.pwdata = imm_q[7:4];
          end
        end
        core_pkg::OP_LDPX_MX_I: begin
          apb_req.pwrite = 1'b1;
          apb_req.paddr  = state.x;
          apb_req.pwdata = imm_q[3:0];
        end
        default: apb_req = '0;
      endcase
    end
  end

  always_comb begin
    wb = '0;
    if (seq_q == S_DONE) begin
      wb.done = 1'b1;
      case (op_q)
        core_pkg::OP_JP: begin
          wb.pc_we   = 1'b1;
          wb.pc      = state.pc;
          wb.pc.step = imm_q;
        end
        core_pkg::OP_CALL: begin
          wb.pc_we   = 1'b1;
          wb.pc      = state.pc;
          wb.pc.step = imm_q;
          wb.sp_we   = 1'b1;
          wb.sp      = state.sp - 8'd3;
        end
        core_pkg::OP_RET,
        core_pkg::OP_RETS,
        core_pkg::OP_RETD: begin
          wb.pc_we   = 1'b1;
          wb.pc.bank = state.pc.bank;
          wb.pc.page = ret_buf_q[11:8];
          wb.pc.step = ret_step;
          wb.sp_we   = 1'b1;
          wb.sp      = state.sp + 8'd3;
          if (op_q == core_pkg::OP_RETD) begin
            wb.x_we = 1'b1;
            wb.x    = state.x + 12'd2;
          end
        end
        core_pkg::OP_LD_A_I: begin
          wb.a_we = 1'b1;
          wb.a    = imm_q[3:0];
        end
        core_pkg::OP_LD_X_E: begin
          wb.x_we = 1'b1;
          wb.x    = {state.x[11:8], imm_q};  // XP untouched
        end
        core_pkg::OP_LDPX_MX_I: begin
          wb.x_we = 1'b1;
          wb.x    = state.x + 12'd1;
        end
        default: wb.done = 1'b1;  // NOP, step advance only
      endcase
    end
  end

endmodule

// ==== rtl/reg_writeback.sv ====
`timescale 1ns/1ps

module reg_writeback #(
  parameter core_pkg::pc_t RESET_PC = 13'h0100,
  parameter logic [7:0]    RESET_SP = 8'h48
) (
  input  logic                  clk,
  input  logic                  rst,
  input  core_pkg::wb_t         wb,
  output core_pkg::arch_state_t state,
  output logic                  retire
);

  core_pkg::pc_t pc_q;
  logic [3:0]    a_q;
  logic [11:0]   x_q;
  logic [7:0]    sp_q;

  // Program counter, explicit load or step advance
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (wb.pc_we) begin
      pc_q <= wb.pc;
    end else if (wb.done) begin
      pc_q.step <= pc_q.step + 8'd1;  // Page is never carried into
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      a_q <= 4'h0;
    end else if (wb.a_we) begin
      a_q <= wb.a;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      x_q <= 12'h000;
    end else if (wb.x_we) begin
      x_q <= wb.x;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sp_q <= RESET_SP;
    end else if (wb.sp_we) begin
      sp_q <= wb.sp;
    end
  end

  // One-cycle pulse, lines up with the updated state
  always_ff @(posedge clk) begin
    if (rst) begin
      retire <= 1'b0;
    end else begin
      retire <= wb.done;
    end
  end

  assign state.pc = pc_q;
  assign state.a  = a_q;
  assign state.x  = x_q;
  assign state.sp = sp_q;

endmodule

// ==== sim.f ====
rtl/core_pkg.sv
rtl/instr_decode.sv
rtl/micro_sequencer.sv
rtl/reg_writeback.sv
rtl/cpu_core.sv
testbench/cpu_core_asserts.sv
testbench/cpu_core_tb.sv

// ==== testbench/cpu_core_asserts.sv ====
`timescale 1ns/1ps

module cpu_core_asserts (
  input logic               clk,
  input logic               rst,
  input core_pkg::apb_req_t apb_req,
  input core_pkg::apb_rsp_t apb_rsp,
  input logic               retire
);

  int enable_errs = 0;
  int hold_errs   = 0;
  int retire_errs = 0;
  int reset_errs  = 0;
  int fail_count;

  assign fail_count = enable_errs + hold_errs + retire_errs + reset_errs;

  // Access phase comes straight out of a setup phase
  assert property (@(posedge clk) disable iff (rst)
    (apb_req.penable && !$past(apb_req.penable)) |-> $past(apb_req.psel && !apb_req.penable))
  else begin
    enable_errs++;
    $error("penable rose without a setup phase");
  end

  // Wait states freeze the whole request
  assert property (@(posedge clk) disable iff (rst)
    (apb_req.psel && apb_req.penable && !apb_rsp.pready) |=> $stable(apb_req))
  else begin
    hold_errs++;
    $error("APB request changed while pready was low");
  end

  assert property (@(posedge clk) disable iff (rst)
    $rose(retire) |-> !apb_req.psel)
  else begin
    retire_errs++;
    $error("retire rose during an APB transfer");
  end

  assert property (@(posedge clk)
    rst |=> (!apb_req.psel && !apb_req.penable))
  else begin
    reset_errs++;
    $error("APB bus not idle after reset");
  end

endmodule

bind cpu_core cpu_core_asserts asserts_i (
  .clk     (clk),
  .rst     (rst),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp),
  .retire  (retire)
);

// ==== testbench/cpu_core_patterns.txt ====
# T name | R rom_addr word | M ram_addr nibble | W addr nibble (expected write, in order)
# E pc a x sp (expected state at each retire, in order) | END closes the test
T jp_ld_wrap
R 0100 E05
R 0101 B3C
R 0102 0FF
R 01FF E03
E 0101 5 000 48
E 0102 5 03C 48
E 01FF 5 03C 48
E 0100 3 03C 48
END
T call_push
R 0100 07A
R 017A 4C3
W 047 1
W 046 7
W 045 B
E 017A 0 000 48
E 01C3 0 000 45
END
T ret_rets
R 0100 FDF
R 074D FDE
M 048 D
M 049 4
M 04A 7
M 04B D
M 04C 4
M 04D 7
E 074D 0 000 4B
E 074E 0 000 4E
END
T retd_ldpx
R 0100 B50
R 0101 1FC
R 0320 E67
M 048 0
M 049 2
M 04A 3
W 050 C
W 051 F
W 052 7
E 0101 0 050 48
E 0320 0 052 4B
E 0321 0 053 4B
END
T nop_unlisted
R 0100 FFB
R 0101 2AB
R 0102 E0D
E 0101 0 000 48
E 0102 0 000 48
E 0103 D 000 48
END

// ==== testbench/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb;

  localparam int    RESET_CYCLES     = 10;
  localparam int    CYCLES_PER_INSTR = 32;  // RETD: five transfers, up to five cycles each
  localparam string PATTERN_FILE     = "testbench/cpu_core_patterns.txt";

  typedef struct packed {
    logic [7:0]  kind;                      // Line tag R, M, W or E
    logic [12:0] addr;
    logic [36:0] data;
  } rec_t;

  logic                  clk;
  logic                  rst;
  core_pkg::pc_t         rom_addr;
  core_pkg::instr_u      rom_data;
  core_pkg::apb_req_t    apb_req;
  core_pkg::apb_rsp_t    apb_rsp;
  logic                  retire;
  core_pkg::arch_state_t state;

  logic [11:0] rom [0:8191];
  logic [3:0]  ram [0:4095];

  rec_t                  recs[$];
  string                 names[$];
  int                    first_rec[$];
  int                    last_rec[$];
  core_pkg::apb_req_t    exp_writes[$];
  core_pkg::arch_state_t exp_states[$];

  logic [31:0] lfsr;
  bit          random_waits;
  bit          timed_out;
  int          wait_left;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;

  cpu_core #(
    .RESET_PC (13'h0100),
    .RESET_SP (8'h48)
  ) dut_i (
    .clk      (clk),
    .rst      (rst),
    .rom_addr (rom_addr),
    .rom_data (rom_data),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .retire   (retire),
    .state    (state)
  );

  assign rom_data = rom[rom_addr];  // Combinational fetch port

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Every fill word has op8 in F0..F7, so it decodes as NOP
  function automatic logic [11:0] rom_fill(input logic [12:0] addr);
    logic [6:0] fold;
    fold = addr[6:0] ^ {1'b0, addr[12:7]};
    return {5'b11110, fold};
  endfunction

  function automatic logic [3:0] ram_fill(input logic [11:0] addr);
    return addr[3:0] ^ addr[7:4] ^ addr[11:8];
  endfunction

  task automatic pick_waits();
    logic [1:0] w;
    if (random_waits) begin
      lfsr = lfsr_next(lfsr);
      w[0] = lfsr[0];
      lfsr = lfsr_next(lfsr);
      w[1] = lfsr[0];
      wait_left = int'(w);
    end else begin
      wait_left = 0;
    end
  endtask

  task automatic check_state(input string sig, input core_pkg::arch_state_t got,
                             input core_pkg::arch_state_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got pc=%h a=%h x=%h sp=%h, expected pc=%h a=%h x=%h sp=%h",
               $time, sig, got.pc, got.a, got.x, got.sp, exp.pc, exp.a, exp.x, exp.sp);
      test_errors++;
    end
  endtask

  task automatic check_write(input string sig, input core_pkg::apb_req_t got,
                             input core_pkg::apb_req_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got sel=%b en=%b wr=%b addr=%h data=%h, %s",
               $time, sig, got.psel, got.penable, got.pwrite, got.paddr, got.pwdata,
               $sformatf("expected sel=%b en=%b wr=%b addr=%h data=%h",
                         exp.psel, exp.penable, exp.pwrite, exp.paddr, exp.pwdata));
      test_errors++;
    end
  endtask

  // RAM slave, called 1 ns after each rising edge
  task automatic serve_apb();
    core_pkg::apb_rsp_t rsp;
    rsp = '0;
    if (apb_req.psel && !apb_req.penable) begin
      pick_waits();
    end else if (apb_req.psel && apb_req.penable) begin
      if (wait_left > 0) begin
        wait_left--;
      end else begin
        rsp.pready = 1'b1;               // Transfer completes on the next edge
        if (apb_req.pwrite) begin
          ram[apb_req.paddr] = apb_req.pwdata;
          if (exp_writes.size() == 0) begin
            $display("unexpected APB write to %h at %0t", apb_req.paddr, $time);
            test_errors++;
          end else begin
            check_write("apb_req", apb_req, exp_writes.pop_front());
          end
        end else begin
          rsp.prdata = ram[apb_req.paddr];
        end
      end
    end
    apb_rsp = rsp;
  endtask

  task automatic read_patterns();
    int          fd;
    int          n;
    string       line;
    string       tag;
    string       name;
    logic [12:0] addr;
    logic [11:0] word;
    logic [12:0] pc;
    logic [3:0]  a;
    logic [11:0] x;
    logic [7:0]  sp;
    rec_t        r;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("cannot open pattern file %s", PATTERN_FILE);
      total_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      tag = "";
      if (n > 0) begin
        n = $sscanf(line, "%s", tag);
      end
      r = '0;
      if (n != 1 || tag.len() == 0 || tag[0] == "#") begin
        continue;
      end else if (tag == "T") begin
        n = $sscanf(line, "%s %s", tag, name);
        names.push_back(name);
        first_rec.push_back(recs.size());
      end else if (tag == "END") begin
        last_rec.push_back(recs.size());
      end else if (tag == "E") begin
        n = $sscanf(line, "%s %h %h %h %h", tag, pc, a, x, sp);
        r.kind = "E";
        r.data = {pc, a, x, sp};
        recs.push_back(r);
      end else if (tag == "R" || tag == "M" || tag == "W") begin
        n = $sscanf(line, "%s %h %h", tag, addr, word);
        r.kind = tag[0];
        r.addr = addr;
        r.data = {25'd0, word};
        recs.push_back(r);
      end else begin
        $display("unknown pattern line: %s", line);
        total_errors++;
      end
    end
    $fclose(fd);
    if (last_rec.size() < first_rec.size()) begin
      $display("pattern file ends inside a test");
      total_errors++;
      last_rec.push_back(recs.size());
    end
  endtask

  task automatic run_test(input int t);
    int                 i;
    int                 cycles;
    int                 limit;
    logic [13:0]        ra;
    logic [12:0]        ma;
    core_pkg::apb_req_t w;
    string              mode;
    @(posedge clk);
    #1;
    rst = 1'b1;
    apb_rsp = '0;
    wait_left = 0;
    test_errors = 0;
    exp_writes.delete();
    exp_states.delete();
    for (ra = 14'd0; ra < 14'd8192; ra++) begin
      rom[ra[12:0]] = rom_fill(ra[12:0]);
    end
    for (ma = 13'd0; ma < 13'd4096; ma++) begin
      ram[ma[11:0]] = ram_fill(ma[11:0]);
    end
    for (i = first_rec[t]; i < last_rec[t]; i++) begin
      if (recs[i].kind == "R") begin
        rom[recs[i].addr] = recs[i].data[11:0];
      end else if (recs[i].kind == "M") begin
        ram[recs[i].addr[11:0]] = recs[i].data[3:0];
      end else if (recs[i].kind == "W") begin
        w = '0;
        w.psel    = 1'b1;
        w.penable = 1'b1;
        w.pwrite  = 1'b1;
        w.paddr   = recs[i].addr[11:0];
        w.pwdata  = recs[i].data[3:0];
        exp_writes.push_back(w);
      end else begin
        exp_states.push_back(recs[i].data);
      end
    end
    limit = exp_states.size() * CYCLES_PER_INSTR + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    cycles = RESET_CYCLES;
    while (exp_states.size() > 0 && cycles < limit) begin
      @(posedge clk);
      #1;
      serve_apb();
      @(negedge clk);
      if (retire) begin
        check_state("state", state, exp_states.pop_front());
      end
      cycles++;
    end
    if (exp_states.size() > 0) begin
      $display("timeout in %s after %0d cycles, %0d retires never came",
               names[t], cycles, exp_states.size());
      timed_out = 1'b1;
      test_errors++;
    end
    if (exp_writes.size() > 0) begin
      $display("%s ended with %0d expected APB writes missing", names[t], exp_writes.size());
      test_errors++;
    end
    if (random_waits) begin
      mode = "random";
    end else begin
      mode = "zero";
    end
    if (test_errors == 0) begin
      $display("test %s, %s wait states: ok", names[t], mode);
    end else begin
      $display("test %s, %s wait states: %0d errors", names[t], mode, test_errors);
      tests_failed++;
    end
    tests_run++;
    total_errors += test_errors;
  endtask

  initial begin
    int round;
    int t;
    int assert_fails;
    rst          = 1'b1;
    apb_rsp      = '0;
    lfsr         = 32'h539d_f0cb;
    random_waits = 1'b0;
    timed_out    = 1'b0;
    wait_left    = 0;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    read_patterns();
    if (names.size() == 0) begin
      $display("no tests found in %s", PATTERN_FILE);
      total_errors++;
    end
    // Second round repeats every test against the same zero-wait results
    for (round = 0; round < 2 && !timed_out; round++) begin
      random_waits = (round == 1);
      for (t = 0; t < names.size() && !timed_out; t++) begin
        run_test(t);
      end
    end
    assert_fails = dut_i.asserts_i.fail_count;
    $display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, total_errors, assert_fails);
    if (timed_out || total_errors != 0 || assert_fails != 0) begin
      $display("Test failed");
    end else begin
      $display("Test passed");
    end
    $finish;
  end

endmodule
